// ==== logic/grom_pkg.sv ====
`default_nettype none

package grom_pkg;

   // bus and address layout
   localparam int grom_byte_w = 8;
   localparam int grom_id_w   = 3;            // chip id on top of the address
   localparam int grom_off_w  = 13;           // byte offset inside a chip
   localparam int grom_addr_w = grom_id_w + grom_off_w;

   // chip geometry
   localparam int grom_chips_per_bank = 4;
   localparam int grom_slot_w         = $clog2(grom_chips_per_bank); // slot inside a bank
   localparam int grom_chip_depth     = 6144; // bytes present per chip

   typedef logic [grom_byte_w-1:0] grom_byte_t;
   typedef logic [grom_id_w-1:0]   grom_id_t;
   typedef logic [grom_off_w-1:0]  grom_off_t;  // wraps inside the chip
   typedef logic [grom_addr_w-1:0] grom_addr_t; // {chip id, offset}

   // an empty slot or a missing byte floats high on the bus
   localparam grom_byte_t grom_absent_byte = 8'hff;

endpackage

`default_nettype wire

// ==== logic/grom_fetch_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface grom_fetch_if
   import grom_pkg::*;
();

   logic       req;     // one-cycle prefetch pulse
   grom_id_t   chip_id; // valid with req
   grom_off_t  offset;  // valid with req
   logic       resp;    // exactly one cycle after req
   grom_byte_t data;    // valid with resp

   modport ctrl (
      output req,
      output chip_id,
      output offset
   );

   modport bank (
      input  req,
      input  chip_id,
      input  offset,
      output resp,
      output data
   );

   modport merge (
      input req,
      input resp,
      input data
   );

endinterface

`default_nettype wire

// ==== logic/grom_addr_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module grom_addr_ctrl
   import grom_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  logic       gs,
   input  logic       m,
   input  logic       mo,
   input  grom_byte_t d,
   input  grom_byte_t buffer,
   output grom_byte_t q,
   grom_fetch_if.ctrl fetch_lo,
   grom_fetch_if.ctrl fetch_hi
);

   grom_addr_t ptr;        // auto-incrementing address pointer
   logic       addr_phase; // next address write completes the pair
   logic       addr_wr;
   logic       addr_rd;
   logic       data_rd;
   logic       prefetch;
   grom_addr_t new_addr;
   grom_addr_t pf_addr;
   logic       req_q;
   grom_id_t   req_id;
   grom_off_t  req_off;

   // step the offset and keep the id
   function automatic grom_addr_t bump_offset(grom_addr_t a);
      grom_off_t off;
      off = a[grom_off_w-1:0] + grom_off_t'(1); // wraps 8191 -> 0
      return {a[grom_addr_w-1:grom_off_w], off};
   endfunction

   // strobe decode
   assign addr_wr = gs && !m && mo;
   assign addr_rd = gs && m && mo;
   assign data_rd = gs && m && !mo;

   assign new_addr = {ptr[grom_byte_w-1:0], d};               // shift in one address byte
   assign prefetch = data_rd || (addr_wr && addr_phase);
   assign pf_addr  = data_rd ? ptr : new_addr;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ptr        <= '0;
         addr_phase <= 1'b0;
         q          <= '0;
      end else if (addr_wr) begin
         ptr        <= addr_phase ? bump_offset(new_addr) : new_addr;
         addr_phase <= !addr_phase;
      end else if (addr_rd) begin
         q          <= ptr[grom_addr_w-1 -: grom_byte_w];      // high byte first
         ptr        <= {ptr[grom_byte_w-1:0], grom_byte_t'(0)};
         addr_phase <= 1'b0;
      end else if (data_rd) begin
         q          <= buffer;                                 // byte fetched earlier
         ptr        <= bump_offset(ptr);
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         req_q <= 1'b0;
      end else begin
         req_q <= prefetch;
      end
   end

   always_ff @(posedge clk) begin
      if (prefetch) begin
         req_id  <= pf_addr[grom_addr_w-1:grom_off_w];
         req_off <= pf_addr[grom_off_w-1:0];
      end
   end

   // same request goes to both banks
   assign fetch_lo.req     = req_q;
   assign fetch_lo.chip_id = req_id;
   assign fetch_lo.offset  = req_off;
   assign fetch_hi.req     = req_q;
   assign fetch_hi.chip_id = req_id;
   assign fetch_hi.offset  = req_off;

   // the host holds off while gready is low, so requests never come back to back
   a_req_spaced: assert property (
      @(posedge clk) disable iff (!arst_n)
      req_q |=> !req_q
   ) else $error("prefetch request issued two cycles in a row");

endmodule

`default_nettype wire

// ==== logic/grom_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module grom_bank
   import grom_pkg::*;
#(
   parameter int bank_sel     = 0,                  // 0: ids 0-3, 1: ids 4-7
   parameter int chips_fitted = grom_chips_per_bank
)(
   input  logic       clk,
   input  logic       arst_n,
   input  logic       load_valid,
   input  grom_addr_t load_addr,
   input  grom_byte_t load_data,
   grom_fetch_if.bank fetch
);

   localparam int mem_slots = (chips_fitted > 0) ? chips_fitted : 1;
   localparam int bank_w    = grom_id_w - grom_slot_w;

   grom_byte_t mem [mem_slots * grom_chip_depth]; // fitted chips back to back
   grom_byte_t rd_byte;
   logic       rd_hit;  // response comes from a real byte
   grom_id_t   load_id;
   grom_off_t  load_off;

   // id in this bank, slot fitted and offset inside the chip
   function automatic logic slot_present(grom_id_t id, grom_off_t off);
      return (id[grom_id_w-1:grom_slot_w] == bank_w'(bank_sel)) &&
             (int'(id[grom_slot_w-1:0]) < chips_fitted) &&
             (int'(off) < grom_chip_depth);
   endfunction

   function automatic int flat_index(grom_id_t id, grom_off_t off);
      return int'(id[grom_slot_w-1:0]) * grom_chip_depth + int'(off);
   endfunction

   assign load_id  = load_addr[grom_addr_w-1:grom_off_w];
   assign load_off = load_addr[grom_off_w-1:0];

   always_ff @(posedge clk) begin
      if (load_valid && slot_present(load_id, load_off)) begin
         mem[flat_index(load_id, load_off)] <= load_data;
      end
      if (fetch.req && slot_present(fetch.chip_id, fetch.offset)) begin
         rd_byte <= mem[flat_index(fetch.chip_id, fetch.offset)];
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         fetch.resp <= 1'b0;
         rd_hit     <= 1'b0;
      end else begin
         fetch.resp <= fetch.req;
         rd_hit     <= fetch.req && slot_present(fetch.chip_id, fetch.offset);
      end
   end

   // foreign id, empty slot or missing offset reads 0xff
   assign fetch.data = rd_hit ? rd_byte : grom_absent_byte;

endmodule

`default_nettype wire

// ==== logic/grom_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module grom_merge
   import grom_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n,
   input  logic        gs,
   grom_fetch_if.merge fetch_lo,
   grom_fetch_if.merge fetch_hi,
   output grom_byte_t  buffer,
   output logic        gready
);

   logic in_flight; // request or response still on its way

   assign in_flight = fetch_lo.req || fetch_hi.req || fetch_lo.resp || fetch_hi.resp;
   assign gready    = !in_flight;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         buffer <= grom_absent_byte;
      end else if (fetch_lo.resp) begin
         buffer <= fetch_lo.data & fetch_hi.data; // wired-AND like the real bus
      end
   end

   // both banks get the same request and answer in the same cycle
   a_resp_aligned: assert property (
      @(posedge clk) disable iff (!arst_n)
      fetch_lo.resp == fetch_hi.resp
   ) else $error("bank responses out of step");

   a_no_strobe_busy: assert property (
      @(posedge clk) disable iff (!arst_n)
      !gready |-> !gs
   ) else $error("host strobe while gready is low");

endmodule

`default_nettype wire

// ==== logic/grom_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module grom_port
   import grom_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  logic       gs,
   input  logic       m,
   input  logic       mo,
   input  grom_byte_t d,
   output grom_byte_t q,
   output logic       gready,
   input  logic       load_valid,
   input  grom_addr_t load_addr,
   input  grom_byte_t load_data
);

   grom_byte_t buffer; // merged prefetch byte

   grom_fetch_if fetch_lo ();
   grom_fetch_if fetch_hi ();

   grom_addr_ctrl i_addr_ctrl (
      .clk      (clk),
      .arst_n   (arst_n),
      .gs       (gs),
      .m        (m),
      .mo       (mo),
      .d        (d),
      .buffer   (buffer),
      .q        (q),
      .fetch_lo (fetch_lo),
      .fetch_hi (fetch_hi)
   );

   // low bank fully fitted
   grom_bank #(
      .bank_sel     (0),
      .chips_fitted (grom_chips_per_bank)
   ) i_bank_lo (
      .clk        (clk),
      .arst_n     (arst_n),
      .load_valid (load_valid),
      .load_addr  (load_addr),
      .load_data  (load_data),
      .fetch      (fetch_lo)
   );

   // high bank, ids 6 and 7 left empty
   grom_bank #(
      .bank_sel     (1),
      .chips_fitted (2)
   ) i_bank_hi (
      .clk        (clk),
      .arst_n     (arst_n),
      .load_valid (load_valid),
      .load_addr  (load_addr),
      .load_data  (load_data),
      .fetch      (fetch_hi)
   );

   grom_merge i_merge (
      .clk      (clk),
      .arst_n   (arst_n),
      .gs       (gs),
      .fetch_lo (fetch_lo),
      .fetch_hi (fetch_hi),
      .buffer   (buffer),
      .gready   (gready)
   );

endmodule

`default_nettype wire

// ==== dv/grom_port_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module grom_port_checker
   import grom_pkg::*;
(
   input logic       clk,
   input logic       arst_n,
   input logic       gs,
   input logic       m,
   input logic       mo,
   input grom_byte_t d,
   input grom_byte_t q,
   input logic       gready,
   input logic       load_valid,
   input grom_addr_t load_addr,
   input grom_byte_t load_data
);

   grom_byte_t model_mem [0:65535]; // every loaded byte, keyed by full address
   grom_addr_t ptr_m;
   logic       phase_m;            // first address byte already written
   grom_byte_t q_m;
   grom_byte_t buf_m;
   grom_byte_t buf_next;          // byte on its way into the buffer
   grom_addr_t new_addr;
   int         busy_m;            // cycles left with gready low
   int         err_count = 0;
   int         check_count = 0;

   // unfitted ids 6 and 7 and offsets past the chip end float high
   function automatic grom_byte_t expected_byte(grom_addr_t a);
      grom_id_t  id;
      grom_off_t off;
      id  = a[grom_addr_w-1:grom_off_w];
      off = a[grom_off_w-1:0];
      if (id > 3'd5 || off >= grom_off_t'(grom_chip_depth)) return grom_absent_byte;
      return model_mem[a];
   endfunction

   // offset steps and wraps while the id stays put
   function automatic grom_addr_t next_offset(grom_addr_t a);
      return (a & 16'he000) | ((a + 16'd1) & 16'h1fff);
   endfunction

   initial begin
      for (int i = 0; i < 65536; i++) model_mem[i] = grom_absent_byte;
   end

   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ptr_m   = '0;
         phase_m = 1'b0;
         q_m     = '0;
         buf_m   = grom_absent_byte;
         busy_m  = 0;
      end else begin
         if (load_valid) begin
            model_mem[load_addr] = load_data;
         end
         check_count++;
         if (q !== q_m) begin
            err_count++;
            $display("ERR %0t: q is %02h, expected %02h", $time, q, q_m);
         end
         if (gready !== (busy_m == 0)) begin
            err_count++;
            $display("ERR %0t: gready is %b, expected %b", $time, gready, busy_m == 0);
         end
         if (busy_m > 0) begin
            busy_m--;
            if (busy_m == 0) buf_m = buf_next; // response has landed
         end
         if (gs) begin
            case ({m, mo})
               2'b01: begin                  // address write
                  new_addr = {ptr_m[7:0], d};
                  if (phase_m) begin
                     buf_next = expected_byte(new_addr);
                     busy_m   = 2;
                     ptr_m    = next_offset(new_addr);
                  end else begin
                     ptr_m = new_addr;
                  end
                  phase_m = !phase_m;
               end
               2'b11: begin                  // address read
                  q_m     = ptr_m[15:8];
                  ptr_m   = ptr_m << 8;
                  phase_m = 1'b0;
               end
               2'b10: begin                  // data read
                  q_m      = buf_m;
                  buf_next = expected_byte(ptr_m);
                  busy_m   = 2;
                  ptr_m    = next_offset(ptr_m);
               end
               default: ;                    // data write is ignored by ROM
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// ==== dv/grom_port_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module grom_port_tb
   import grom_pkg::*;
();

   localparam int load_len       = 6 * grom_chip_depth; // ids 0 to 5
   localparam int max_strobes    = 512;
   localparam int timeout_cycles = load_len + max_strobes * 8 + 500;

   logic        clk = 1'b0;
   logic        arst_n;
   logic        gs;
   logic        m;
   logic        mo;
   grom_byte_t  d;
   grom_byte_t  q;
   logic        gready;
   logic        load_valid;
   grom_addr_t  load_addr;
   grom_byte_t  load_data;
   logic [31:0] rng_state = 32'd92;
   int          cycle_count = 0;
   int          test_num;
   int          errs_before;

   always #5 clk = ~clk;

   grom_port i_grom_port (
      .clk        (clk),
      .arst_n     (arst_n),
      .gs         (gs),
      .m          (m),
      .mo         (mo),
      .d          (d),
      .q          (q),
      .gready     (gready),
      .load_valid (load_valid),
      .load_addr  (load_addr),
      .load_data  (load_data)
   );

   grom_port_checker i_checker (
      .clk        (clk),
      .arst_n     (arst_n),
      .gs         (gs),
      .m          (m),
      .mo         (mo),
      .d          (d),
      .q          (q),
      .gready     (gready),
      .load_valid (load_valid),
      .load_addr  (load_addr),
      .load_data  (load_data)
   );

   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   function automatic grom_addr_t loaded_addr();
      return {grom_id_t'(next_rand() % 6), grom_off_t'(next_rand() % grom_chip_depth)};
   endfunction

   // one host strobe once the port is ready
   task automatic strobe(input logic sm, input logic smo, input grom_byte_t sd);
      @(negedge clk);
      while (!gready) @(negedge clk);
      @(posedge clk);
      gs <= 1'b1;
      m  <= sm;
      mo <= smo;
      d  <= sd;
      @(posedge clk);
      gs <= 1'b0;
   endtask

   task automatic set_address(input grom_addr_t a);
      strobe(1'b0, 1'b1, a[15:8]);
      strobe(1'b0, 1'b1, a[7:0]);
   endtask

   task automatic idle_gap();
      repeat (int'(next_rand() % 4)) @(posedge clk);
   endtask

   task automatic read_bytes(input int n);
      repeat (n) begin
         strobe(1'b1, 1'b0, 8'h00);
         idle_gap();
      end
   endtask

   task automatic finish_test(input string name);
      @(negedge clk);
      while (!gready) @(negedge clk);
      repeat (2) @(posedge clk); // last q compare has happened
      $display("test %0d %s: %0d errors", test_num, name, i_checker.err_count - errs_before);
      errs_before = i_checker.err_count;
      test_num++;
   endtask

   initial begin
      while (cycle_count < timeout_cycles) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("Simulation failed");
      $finish;
   end

   initial begin
      logic [31:0] r;
      arst_n      = 1'b0;
      gs          = 1'b0;
      m           = 1'b0;
      mo          = 1'b0;
      d           = '0;
      load_valid  = 1'b0;
      load_addr   = '0;
      load_data   = '0;
      test_num    = 1;
      errs_before = 0;
      repeat (4) @(posedge clk);
      arst_n <= 1'b1;

      for (int i = 0; i < load_len; i++) begin
         @(posedge clk);
         load_valid <= 1'b1;
         load_addr  <= {grom_id_t'(i / grom_chip_depth), grom_off_t'(i % grom_chip_depth)};
         load_data  <= grom_byte_t'(next_rand());
      end
      @(posedge clk);
      load_valid <= 1'b0;

      set_address(loaded_addr());
      read_bytes(1);
      finish_test("address write then data read");

      set_address({grom_id_t'(next_rand() % 6), 13'd6141}); // runs past the chip end
      read_bytes(5);
      set_address({grom_id_t'(next_rand() % 6), 13'd8190}); // offset wraps to 0
      read_bytes(4);
      set_address(loaded_addr());
      read_bytes(6);
      finish_test("sequential reads and offset wrap");

      for (int id = 4; id < 8; id++) begin
         set_address({grom_id_t'(id), grom_off_t'(next_rand() % grom_chip_depth)});
         read_bytes(2);
      end
      finish_test("high bank fitted and empty slots");

      set_address(loaded_addr());
      strobe(1'b1, 1'b1, 8'h00);
      strobe(1'b1, 1'b1, 8'h00);
      read_bytes(1);
      finish_test("address reads");

      repeat (200) begin
         r = next_rand();
         case (r[1:0])
            2'd0: begin
               if (r[2]) begin
                  set_address(grom_addr_t'(next_rand()));
               end else begin
                  strobe(1'b0, 1'b1, grom_byte_t'(next_rand())); // lone address byte
               end
            end
            2'd1: strobe(1'b1, 1'b1, 8'h00);
            2'd2: strobe(1'b1, 1'b0, 8'h00);
            default: strobe(1'b0, 1'b0, grom_byte_t'(next_rand()));
         endcase
         idle_gap();
      end
      finish_test("random strobes and gready timing");

      $display("tests %0d, checks %0d, errors %0d",
               test_num - 1, i_checker.check_count, i_checker.err_count);
      if (i_checker.err_count == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== grom_port.f ====
logic/grom_pkg.sv
logic/grom_fetch_if.sv
logic/grom_addr_ctrl.sv
logic/grom_bank.sv
logic/grom_merge.sv
logic/grom_port.sv
dv/grom_port_checker.sv
dv/grom_port_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the GROM port testbench with Verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f grom_port.f --top-module grom_port_tb \
   -o grom_port_sim \
   && ./obj_dir/grom_port_sim > sim.log 2>&1 \
   || echo "build or simulation run failed"

cat sim.log 2>/dev/null
grep -qx "Simulation passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
